//--- Bender.yml
package:
  name: mont_exp

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/mont_pkg.sv
      - logic/mont_mult.sv
      - logic/square_streamer.sv
      - logic/square_fifo.sv
      - logic/mont_accumulator.sv
      - logic/mont_exp_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/mont_exp_tb.sv

//--- files.f
+incdir+include
logic/mont_pkg.sv
logic/mont_mult.sv
logic/square_streamer.sv
logic/square_fifo.sv
logic/mont_accumulator.sv
logic/mont_exp_top.sv
verif/mont_exp_tb.sv

//--- include/mont_config.svh
`ifndef MONT_CONFIG_SVH
`define MONT_CONFIG_SVH

// operand and modulus width, R = 2**OPERAND_BITS
`define OPERAND_BITS 32

// square items held between streamer and accumulator, power of two
`define SQ_FIFO_DEPTH 4

`endif

//--- logic/mont_accumulator.sv
`default_nettype none

// consumer, multiplies in the squares whose exponent bit is set
module mont_accumulator import mont_pkg::*; (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     start,
    input  operand_t modulus,
    input  operand_t r_sq,
    input  sq_item_t item,
    input  logic     fifo_empty,
    output logic     item_read,
    output operand_t result,
    output logic     result_valid,
    output logic     busy
);

    localparam operand_t ONE = operand_t'(1);

    accum_state_t state;
    operand_t     acc_q;    // running product, montgomery form until the end
    operand_t     n_q;
    logic         last_q;
    logic         ready;

    logic     mult_start;
    logic     mult_done;
    operand_t mult_a;
    operand_t mult_b;
    operand_t mult_n;
    operand_t mult_result;

    // done counts as ready so a start can follow result_valid directly
    assign ready        = (state == ac_idle) || (state == ac_done);
    assign busy         = !ready;
    assign result_valid = (state == ac_done);
    assign result       = acc_q;
    assign item_read    = (state == ac_wait_item) && !fifo_empty;

    always_comb begin
        mult_n = ready ? modulus : n_q;
        case (state)
            ac_idle, ac_done: begin
                mult_a = r_sq;      // R^2 * 1 * R^-1 = R mod N
                mult_b = ONE;
            end
            ac_wait_item: begin
                mult_a = acc_q;
                mult_b = item.exp_bit ? item.square : ONE;   // one on a clear last bit
            end
            ac_multiply: begin
                mult_a = mult_result;   // chain straight into the final multiply
                mult_b = ONE;
            end
            default: begin
                mult_a = acc_q;
                mult_b = ONE;
            end
        endcase
    end

    assign mult_start = (ready && start)
                      || (item_read && (item.exp_bit || item.last))
                      || ((state == ac_multiply) && mult_done && last_q);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state  <= ac_idle;
            last_q <= 1'b0;
        end else begin
            case (state)
                ac_idle: begin
                    if (start) state <= ac_init;
                end
                ac_done: state <= start ? ac_init : ac_idle;
                ac_init: begin
                    if (mult_done) state <= ac_wait_item;
                end
                ac_wait_item: begin
                    if (item_read) begin
                        last_q <= item.last;
                        if (item.exp_bit) begin
                            state <= ac_multiply;
                        end else if (item.last) begin
                            state <= ac_from_mont;
                        end
                    end
                end
                ac_multiply: begin
                    if (mult_done) state <= last_q ? ac_from_mont : ac_wait_item;
                end
                ac_from_mont: begin
                    if (mult_done) state <= ac_done;
                end
                default: state <= ac_idle;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (ready && start) n_q <= modulus;
        if (mult_done) acc_q <= mult_result;
    end

    mont_mult multiplier0 (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .start   (mult_start),
        .a       (mult_a),
        .b       (mult_b),
        .modulus (mult_n),
        .done    (mult_done),
        .result  (mult_result)
    );

endmodule

`default_nettype wire

//--- logic/mont_exp_top.sv
`default_nettype none

// base^exponent mod modulus
module mont_exp_top import mont_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_in,
    input  logic      start,
    input  operand_t  base,
    input  exponent_t exponent,
    input  operand_t  modulus,
    input  operand_t  r_sq,       // R^2 mod N from the host
    output operand_t  result,
    output logic      result_valid,
    output logic      busy
);

    logic     start_accepted;
    sq_item_t wr_item;
    logic     wr_strobe;
    sq_item_t rd_item;
    logic     rd_strobe;
    logic     fifo_full;
    logic     fifo_empty;

    assign start_accepted = start && !busy;   // one place decides for both sides

    square_streamer streamer0 (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .start      (start_accepted),
        .base       (base),
        .exponent   (exponent),
        .modulus    (modulus),
        .r_sq       (r_sq),
        .fifo_full  (fifo_full),
        .item       (wr_item),
        .item_write (wr_strobe)
    );

    square_fifo fifo0 (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .write      (wr_strobe),
        .write_item (wr_item),
        .read       (rd_strobe),
        .read_item  (rd_item),
        .full       (fifo_full),
        .empty      (fifo_empty)
    );

    mont_accumulator accum0 (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .start        (start_accepted),
        .modulus      (modulus),
        .r_sq         (r_sq),
        .item         (rd_item),
        .fifo_empty   (fifo_empty),
        .item_read    (rd_strobe),
        .result       (result),
        .result_valid (result_valid),
        .busy         (busy)
    );

endmodule

`default_nettype wire

//--- logic/mont_mult.sv
`default_nettype none

`include "mont_config.svh"

// radix-2 montgomery product a*b*R^-1 mod N, one bit of a per cycle
module mont_mult import mont_pkg::*; (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     start,
    input  operand_t a,
    input  operand_t b,
    input  operand_t modulus,
    output logic     done,
    output operand_t result
);

    localparam int WIDE_BITS = `OPERAND_BITS + 2;
    localparam int CNT_BITS  = $clog2(`OPERAND_BITS + 1);
    localparam logic [CNT_BITS-1:0] STEPS = CNT_BITS'(`OPERAND_BITS);

    typedef logic [WIDE_BITS-1:0] wide_t;

    logic                running;
    logic [CNT_BITS-1:0] step_cnt;
    wide_t               partial;   // stays below 2N
    operand_t            a_sh;
    operand_t            b_q;
    operand_t            n_q;

    function automatic wide_t mont_step(wide_t p, logic a_bit, operand_t bv, operand_t nv);
        wide_t sum;
        sum = p + (a_bit ? wide_t'(bv) : '0);
        if (sum[0]) begin
            sum = sum + wide_t'(nv);    // make it even
        end
        return sum >> 1;
    endfunction

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            running  <= 1'b0;
            done     <= 1'b0;
            step_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running  <= 1'b1;
                step_cnt <= CNT_BITS'(1);   // first step taken on the start edge
            end else if (running) begin
                if (step_cnt == STEPS) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end else begin
                    step_cnt <= step_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (start) begin
            partial <= mont_step('0, a[0], b, modulus);
            a_sh    <= a >> 1;
            b_q     <= b;
            n_q     <= modulus;
        end else if (running) begin
            if (step_cnt == STEPS) begin
                // final conditional subtraction
                result <= (partial >= wide_t'(n_q)) ? operand_t'(partial - wide_t'(n_q))
                                                    : operand_t'(partial);
            end else begin
                partial <= mont_step(partial, a_sh[0], b_q, n_q);
                a_sh    <= a_sh >> 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mont_pkg.sv
`default_nettype none

`include "mont_config.svh"

package mont_pkg;

    typedef logic [`OPERAND_BITS-1:0] operand_t;   // residue or modulus
    typedef logic [`OPERAND_BITS-1:0] exponent_t;

    typedef struct packed {
        operand_t square;   // montgomery form
        logic     exp_bit;  // exponent bit this square belongs to
        logic     last;     // top exponent bit
    } sq_item_t;

    typedef enum logic [1:0] {
        st_idle,
        st_to_mont,
        st_emit,
        st_square
    } streamer_state_t;

    typedef enum logic [2:0] {
        ac_idle,
        ac_init,
        ac_wait_item,
        ac_multiply,
        ac_from_mont,
        ac_done
    } accum_state_t;

endpackage

`default_nettype wire

//--- logic/square_fifo.sv
`default_nettype none

`include "mont_config.svh"

// circular buffer, head item shown combinationally
module square_fifo import mont_pkg::*; (
    input  logic     clk_in,
    input  logic     rst_in,
    input  logic     write,
    input  sq_item_t write_item,
    input  logic     read,
    output sq_item_t read_item,
    output logic     full,
    output logic     empty
);

    localparam int PTR_BITS = $clog2(`SQ_FIFO_DEPTH);
    localparam int CNT_BITS = $clog2(`SQ_FIFO_DEPTH + 1);
    localparam logic [CNT_BITS-1:0] DEPTH = CNT_BITS'(`SQ_FIFO_DEPTH);

    sq_item_t            mem [`SQ_FIFO_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push;
    logic                pop;

    assign full      = (count == DEPTH);
    assign empty     = (count == '0);
    assign push      = write && !full;   // writes into a full buffer are dropped
    assign pop       = read && !empty;
    assign read_item = mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;   // pointers wrap at depth
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (push) mem[wr_ptr] <= write_item;
    end

endmodule

`default_nettype wire

//--- logic/square_streamer.sv
`default_nettype none

`include "mont_config.svh"

// producer of base^(2^i) in montgomery form, one item per exponent bit
module square_streamer import mont_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_in,
    input  logic      start,
    input  operand_t  base,
    input  exponent_t exponent,
    input  operand_t  modulus,
    input  operand_t  r_sq,
    input  logic      fifo_full,
    output sq_item_t  item,
    output logic      item_write
);

    localparam int CNT_BITS = $clog2(`OPERAND_BITS);
    localparam logic [CNT_BITS-1:0] LAST_BIT = CNT_BITS'(`OPERAND_BITS - 1);

    streamer_state_t     state;
    logic [CNT_BITS-1:0] bit_cnt;
    exponent_t           exp_q;     // shifted so bit 0 tags the next item
    operand_t            n_q;
    operand_t            square_q;
    logic                last_item;

    logic     mult_start;
    logic     mult_done;
    operand_t mult_a;
    operand_t mult_b;
    operand_t mult_n;
    operand_t mult_result;

    assign last_item  = (bit_cnt == LAST_BIT);
    assign item_write = (state == st_emit) && !fifo_full;   // hold while full

    always_comb begin
        item.square  = square_q;
        item.exp_bit = exp_q[0];
        item.last    = last_item;
    end

    // base*R^2 on start, square of the current value otherwise
    always_comb begin
        if (state == st_idle) begin
            mult_a = base;
            mult_b = r_sq;
            mult_n = modulus;
        end else begin
            mult_a = square_q;
            mult_b = square_q;
            mult_n = n_q;
        end
    end

    // no squaring needed after the top item
    assign mult_start = ((state == st_idle) && start) || (item_write && !last_item);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state   <= st_idle;
            bit_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        bit_cnt <= '0;
                        state   <= st_to_mont;
                    end
                end
                st_to_mont, st_square: begin
                    if (mult_done) state <= st_emit;
                end
                st_emit: begin
                    if (item_write) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        state   <= last_item ? st_idle : st_square;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if ((state == st_idle) && start) begin
            exp_q <= exponent;
            n_q   <= modulus;
        end else if (item_write) begin
            exp_q <= exp_q >> 1;
        end
        if (mult_done) square_q <= mult_result;
    end

    mont_mult squarer0 (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .start   (mult_start),
        .a       (mult_a),
        .b       (mult_b),
        .modulus (mult_n),
        .done    (mult_done),
        .result  (mult_result)
    );

endmodule

`default_nettype wire

//--- verif/mont_exp_tb.sv
`default_nettype none

`include "mont_config.svh"

module mont_exp_tb import mont_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_DIRECTED = 9;
    localparam int NUM_RANDOM   = 4;
    localparam int NUM_TESTS    = NUM_DIRECTED + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES =
        NUM_TESTS * (2 * `OPERAND_BITS + 3) * (`OPERAND_BITS + 2) + 100;
    // streamer has written its last item, accumulator still busy
    localparam int LATE_STRAY_CYCLE = `OPERAND_BITS * (`OPERAND_BITS + 2) + 4;

    typedef struct packed {
        operand_t  base;
        exponent_t exponent;
        operand_t  modulus;
        operand_t  r_sq;
        operand_t  expected;
        logic      stray_start;   // poke start again while busy
    } test_vec_t;

    logic      clk_in;
    logic      rst_in;
    logic      start;
    operand_t  base;
    exponent_t exponent;
    operand_t  modulus;
    operand_t  r_sq;
    operand_t  result;
    logic      result_valid;
    logic      busy;

    test_vec_t tests [NUM_TESTS];
    string     test_names [NUM_TESTS];
    int        num_loaded = 0;
    int        pulse_count = 0;
    int        cycle_count = 0;
    integer    seed = 47837;

    mont_exp_top dut0 (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .start        (start),
        .base         (base),
        .exponent     (exponent),
        .modulus      (modulus),
        .r_sq         (r_sq),
        .result       (result),
        .result_valid (result_valid),
        .busy         (busy)
    );

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_result(input string name, input operand_t expected,
                                input operand_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // R^2 mod N, doubling 1 once per bit of R^2
    function automatic operand_t r_sq_model(operand_t n);
        logic [63:0] r;
        r = 64'd1;
        for (int i = 0; i < 2 * `OPERAND_BITS; i++) begin
            r = r << 1;
            if (r >= {32'd0, n}) r = r - {32'd0, n};
        end
        return operand_t'(r);
    endfunction

    function automatic operand_t mod_exp_model(operand_t b, exponent_t e, operand_t n);
        logic [63:0] acc;
        logic [63:0] sq;
        acc = 64'd1 % {32'd0, n};
        sq  = {32'd0, b} % {32'd0, n};
        for (int i = 0; i < `OPERAND_BITS; i++) begin
            if (e[i]) acc = (acc * sq) % {32'd0, n};
            sq = (sq * sq) % {32'd0, n};
        end
        return operand_t'(acc);
    endfunction

    task automatic add_test(input string name, input operand_t b, input exponent_t e,
                            input operand_t n, input logic stray);
        test_names[num_loaded]            = name;
        tests[num_loaded].base            = b;
        tests[num_loaded].exponent        = e;
        tests[num_loaded].modulus         = n;
        tests[num_loaded].r_sq            = r_sq_model(n);
        tests[num_loaded].expected        = mod_exp_model(b, e, n);
        tests[num_loaded].stray_start     = stray;
        num_loaded++;
    endtask

    task automatic run_test(input int idx);
        test_vec_t tv;
        int        cycles;
        logic      got;
        tv     = tests[idx];
        cycles = 0;
        got    = 1'b0;
        @(posedge clk_in);
        start    <= 1'b1;
        base     <= tv.base;
        exponent <= tv.exponent;
        modulus  <= tv.modulus;
        r_sq     <= tv.r_sq;
        @(posedge clk_in);
        start <= 1'b0;
        @(negedge clk_in);
        if (!busy) begin
            stop_on_error($sformatf("busy did not rise after start of %s", test_names[idx]));
        end
        while (!got) begin
            @(posedge clk_in);
            if (tv.stray_start && (cycles == 4 || cycles == LATE_STRAY_CYCLE)) begin
                start    <= 1'b1;   // different operands, must not be taken
                base     <= 32'd2;
                exponent <= 32'd3;
                modulus  <= 32'd101;
                r_sq     <= r_sq_model(32'd101);
            end else begin
                start <= 1'b0;
            end
            @(negedge clk_in);
            cycles++;
            if (result_valid) begin
                got = 1'b1;
                if (busy) stop_on_error($sformatf("busy still high at result of %s",
                                                  test_names[idx]));
            end else if (!busy) begin
                stop_on_error($sformatf("busy fell before result of %s", test_names[idx]));
            end
        end
        check_result(test_names[idx], tv.expected, result);
        repeat (3) begin
            @(negedge clk_in);
            if (busy || result_valid) begin
                stop_on_error($sformatf("activity after result of %s", test_names[idx]));
            end
        end
        @(posedge clk_in);
        if (pulse_count != idx + 1) begin
            stop_on_error($sformatf("%0d result pulses seen after %s, expected %0d",
                                    pulse_count, test_names[idx], idx + 1));
        end
    endtask

    always @(negedge clk_in) begin
        if (result_valid) pulse_count <= pulse_count + 1;
    end

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) stop_on_error("timeout, the run took too many cycles");
    end

    initial begin
        operand_t  rnd_n;
        operand_t  rnd_b;
        exponent_t rnd_e;
        rst_in   = 1'b1;
        start    = 1'b0;
        base     = '0;
        exponent = '0;
        modulus  = 32'd3;
        r_sq     = '0;

        add_test("exp0_small", 32'd5, 32'd0, 32'd13, 1'b0);
        add_test("exp1_small", 32'd5, 32'd1, 32'd13, 1'b0);
        add_test("exp0_top_bit_mod", 32'h1234_5678, 32'd0, 32'hFFFF_FFFB, 1'b0);
        add_test("exp1_top_bit_mod", 32'h8765_4321, 32'd1, 32'hFFFF_FFFB, 1'b0);
        add_test("textbook", 32'd4, 32'd13, 32'd497, 1'b1);
        add_test("all_ones_exp", 32'h0BAD_F00D, 32'hFFFF_FFFF, 32'hFFFF_FFFB, 1'b1);
        add_test("top_exp_bit_only", 32'd3, 32'h8000_0000, 32'hC000_0001, 1'b0);
        add_test("fermat", 32'd7, 32'hFFFF_FFFA, 32'hFFFF_FFFB, 1'b0);
        add_test("mod_three", 32'd2, 32'h5555_5555, 32'd3, 1'b0);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd_n    = $random(seed);
            rnd_n[0] = 1'b1;
            if (rnd_n < 32'd3) rnd_n = 32'd3;
            rnd_b = $random(seed);
            rnd_b = rnd_b % rnd_n;
            rnd_e = $random(seed);
            add_test($sformatf("random_%0d", i), rnd_b, rnd_e, rnd_n, 1'b0);
        end

        repeat (3) @(posedge clk_in);
        rst_in <= 1'b0;
        repeat (4) begin
            @(negedge clk_in);
            if (busy || result_valid) stop_on_error("busy or result_valid high after reset");
        end

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire
